//--- dcachePkg.sv
package dcachePkg;

    // ==============================
    // cache geometry
    // ==============================
    localparam int NumWays = 4;
    localparam int NumSets = 128;
    localparam int TagW = 20;
    localparam int IndexW = 7;
    localparam int WordSelW = 3;
    localparam int WordsPerLine = 1 << WordSelW;
    localparam int LineW = WordsPerLine * 32;

    // physical address, raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TagW-1:0]     tag;
            logic [IndexW-1:0]   index;
            logic [WordSelW-1:0] wordSel;
            logic [1:0]          byteOff;
        } f;
    } cacheAddrT;

    typedef logic [LineW-1:0] lineT;

    // one bit per way
    typedef logic [NumWays-1:0] wayVecT;

endpackage

//--- reqArbiter.sv
`timescale 1ns/1ps

module reqArbiter (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  LoadAble,
    input  dcachePkg::cacheAddrT  LoadAddr,
    input  logic [2:0]            LoadPtr,
    input  logic                  StoreAble,
    input  dcachePkg::cacheAddrT  StoreAddr,
    input  logic [2:0]            StorePtr,
    input  logic [31:0]           StoreData,
    input  logic                  RefillAble,
    output logic                  LoadSuccess,
    output logic                  StoreSuccess,
    output logic                  reqValid,
    output logic                  reqIsStore,
    output dcachePkg::cacheAddrT  reqAddr,
    output logic [2:0]            reqPtr,
    output logic [31:0]           reqData
);

    logic loadReq;
    logic storeReq;
    logic tieLoadLast;
    logic pickLoad;
    logic pickStore;

    // a side granted last cycle still holds its level during the Success pulse
    assign loadReq = LoadAble && !LoadSuccess && !RefillAble;
    assign storeReq = StoreAble && !StoreSuccess && !RefillAble;

    // each side wins alone, or on a tie when the other side won the last tie
    assign pickLoad = loadReq && (!storeReq || !tieLoadLast);
    assign pickStore = storeReq && (!loadReq || tieLoadLast);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            LoadSuccess <= 1'b0;
            StoreSuccess <= 1'b0;
            reqValid <= 1'b0;
            tieLoadLast <= 1'b0;
        end else begin
            LoadSuccess <= pickLoad;
            StoreSuccess <= pickStore;
            reqValid <= pickLoad || pickStore;
            if (loadReq && storeReq) begin
                tieLoadLast <= pickLoad;
            end
        end
    end

    // stage-1 request register
    always_ff @(posedge Clk) begin
        reqIsStore <= pickStore;
        reqAddr <= pickStore ? StoreAddr : LoadAddr;
        reqPtr <= pickStore ? StorePtr : LoadPtr;
        reqData <= StoreData;
    end

    grantExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(LoadSuccess && StoreSuccess));

endmodule

//--- tagArray.sv
`timescale 1ns/1ps

module tagArray (
    input  logic                                                 Clk,
    input  logic                                                 rstN,
    input  logic [dcachePkg::IndexW-1:0]                         lookIndex,
    input  logic                                                 RefillAble,
    input  dcachePkg::cacheAddrT                                 RefillAddr,
    input  dcachePkg::wayVecT                                    RefillWay,
    output logic [dcachePkg::NumWays-1:0][dcachePkg::TagW-1:0]   wayTags,
    output dcachePkg::wayVecT                                    wayValid
);

    logic [dcachePkg::NumWays-1:0][dcachePkg::TagW-1:0] tags [dcachePkg::NumSets];
    dcachePkg::wayVecT valid [dcachePkg::NumSets];

    always_ff @(posedge Clk) begin
        if (RefillAble) begin
            for (int w = 0; w < dcachePkg::NumWays; w++) begin
                if (RefillWay[w]) begin
                    tags[RefillAddr.f.index][w] <= RefillAddr.f.tag;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int s = 0; s < dcachePkg::NumSets; s++) begin
                valid[s] <= '0;
            end
        end else if (RefillAble) begin
            valid[RefillAddr.f.index] <= valid[RefillAddr.f.index] | RefillWay;
        end
    end

    // combinational read of the looked-up set
    assign wayTags = tags[lookIndex];
    assign wayValid = valid[lookIndex];

endmodule

//--- dataArray.sv
`timescale 1ns/1ps

module dataArray (
    input  logic                                     Clk,
    input  logic [dcachePkg::IndexW-1:0]             lookIndex,
    input  logic                                     wrWordEn,
    input  dcachePkg::wayVecT                        wrWay,
    input  logic [dcachePkg::WordSelW-1:0]           wrWordSel,
    input  logic [31:0]                              wrWord,
    input  logic                                     RefillAble,
    input  dcachePkg::cacheAddrT                     RefillAddr,
    input  dcachePkg::wayVecT                        RefillWay,
    input  dcachePkg::lineT                          RefillLine,
    output dcachePkg::lineT [dcachePkg::NumWays-1:0] wayLines
);

    dcachePkg::lineT [dcachePkg::NumWays-1:0] lines [dcachePkg::NumSets];

    always_ff @(posedge Clk) begin
        for (int w = 0; w < dcachePkg::NumWays; w++) begin
            // store hit updates a single word of the hit way
            if (wrWordEn && wrWay[w]) begin
                lines[lookIndex][w][wrWordSel * $bits(wrWord) +: $bits(wrWord)] <= wrWord;
            end
            if (RefillAble && RefillWay[w]) begin
                lines[RefillAddr.f.index][w] <= RefillLine;
            end
        end
    end

    assign wayLines = lines[lookIndex];

    // refill targets a way the miss handler owns, never a line being stored to
    noWriteClash: assert property (@(posedge Clk)
        !(wrWordEn && RefillAble && (RefillAddr.f.index == lookIndex)
          && |(wrWay & RefillWay)));

endmodule

//--- replacementState.sv
`timescale 1ns/1ps

module replacementState #(
    parameter int AgeBits = 3
) (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic [dcachePkg::IndexW-1:0]  lookIndex,
    input  dcachePkg::wayVecT             wayValid,
    input  logic                          hitEn,
    input  dcachePkg::wayVecT             hitWay,
    input  logic                          dirtySetEn,
    input  logic                          cleanEn,
    input  dcachePkg::wayVecT             cleanWay,
    input  logic                          RefillAble,
    input  dcachePkg::cacheAddrT          RefillAddr,
    input  dcachePkg::wayVecT             RefillWay,
    output dcachePkg::wayVecT             victimWay,
    output logic                          victimDirty
);

    logic [dcachePkg::NumWays-1:0][AgeBits-1:0] age [dcachePkg::NumSets];
    dcachePkg::wayVecT dirty [dcachePkg::NumSets];
    logic [AgeBits-1:0] bestAge;

    function automatic logic [AgeBits-1:0] satInc(input logic [AgeBits-1:0] a);
        return (a == {AgeBits{1'b1}}) ? a : a + 1'b1;
    endfunction

    // ==============================
    // age counters and dirty bits
    // ==============================
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int s = 0; s < dcachePkg::NumSets; s++) begin
                age[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            for (int w = 0; w < dcachePkg::NumWays; w++) begin
                if (hitEn) begin
                    age[lookIndex][w] <= hitWay[w] ? '0 : satInc(age[lookIndex][w]);
                end
                // refill comes last so it wins on a shared set
                if (RefillAble) begin
                    age[RefillAddr.f.index][w] <= RefillWay[w] ? '0
                        : satInc(age[RefillAddr.f.index][w]);
                end
                if (dirtySetEn && hitWay[w]) begin
                    dirty[lookIndex][w] <= 1'b1;
                end
                if (cleanEn && cleanWay[w]) begin
                    dirty[lookIndex][w] <= 1'b0;
                end
                if (RefillAble && RefillWay[w]) begin
                    dirty[RefillAddr.f.index][w] <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // victim choice
    // ==============================
    always_comb begin
        victimWay = dcachePkg::wayVecT'(1);
        bestAge = age[lookIndex][0];
        // oldest way, strict compare keeps the lowest index on ties
        for (int w = 1; w < dcachePkg::NumWays; w++) begin
            if (age[lookIndex][w] > bestAge) begin
                bestAge = age[lookIndex][w];
                victimWay = dcachePkg::wayVecT'(1) << w;
            end
        end
        // any invalid way overrides, lowest index last
        for (int w = dcachePkg::NumWays - 1; w >= 0; w--) begin
            if (!wayValid[w]) begin
                victimWay = dcachePkg::wayVecT'(1) << w;
            end
        end
    end

    assign victimDirty = |(victimWay & dirty[lookIndex]);

endmodule

//--- lookupStage.sv
`timescale 1ns/1ps

module lookupStage (
    input  logic                                                Clk,
    input  logic                                                rstN,
    input  logic                                                reqValid,
    input  logic                                                reqIsStore,
    input  dcachePkg::cacheAddrT                                reqAddr,
    input  logic [2:0]                                          reqPtr,
    input  logic [31:0]                                         reqData,
    input  logic [dcachePkg::NumWays-1:0][dcachePkg::TagW-1:0]  wayTags,
    input  dcachePkg::wayVecT                                   wayValid,
    input  dcachePkg::lineT [dcachePkg::NumWays-1:0]            wayLines,
    input  dcachePkg::wayVecT                                   victimWay,
    input  logic                                                victimDirty,
    output logic                                                hitEn,
    output dcachePkg::wayVecT                                   hitWay,
    output logic                                                wrWordEn,
    output logic                                                dirtySetEn,
    output logic                                                cleanEn,
    output dcachePkg::wayVecT                                   cleanWay,
    output logic                                                LoadBack,
    output logic [2:0]                                          LoadBackPtr,
    output logic [31:0]                                         LoadBackData,
    output logic                                                StoreBack,
    output logic [2:0]                                          StoreBackPtr,
    output logic                                                MissAble,
    output dcachePkg::cacheAddrT                                MissAddr,
    output dcachePkg::wayVecT                                   MissWay,
    output logic                                                MissIsStore,
    output logic [2:0]                                          MissPtr,
    output logic [31:0]                                         MissStoreData,
    output logic                                                WriteBackAble,
    output dcachePkg::cacheAddrT                                WriteBackAddr,
    output dcachePkg::lineT                                     WriteBackLine
);

    logic missEn;
    dcachePkg::lineT hitLine;
    dcachePkg::lineT victimLine;
    logic [dcachePkg::TagW-1:0] victimTag;
    dcachePkg::cacheAddrT lineAddr;
    dcachePkg::cacheAddrT victimAddr;

    // ==============================
    // tag compare and way muxing
    // ==============================
    always_comb begin
        hitLine = '0;
        victimLine = '0;
        victimTag = '0;
        for (int w = 0; w < dcachePkg::NumWays; w++) begin
            hitWay[w] = wayValid[w] && (wayTags[w] == reqAddr.f.tag);
            if (hitWay[w]) begin
                hitLine = hitLine | wayLines[w];
            end
            if (victimWay[w]) begin
                victimLine = victimLine | wayLines[w];
                victimTag = victimTag | wayTags[w];
            end
        end
    end

    assign hitEn = reqValid && |hitWay;
    assign missEn = reqValid && !(|hitWay);
    assign wrWordEn = hitEn && reqIsStore;
    assign dirtySetEn = wrWordEn;
    assign cleanEn = missEn && victimDirty;
    assign cleanWay = victimWay;

    always_comb begin
        lineAddr = reqAddr;
        lineAddr.f.wordSel = '0;
        lineAddr.f.byteOff = '0;
        victimAddr = lineAddr;
        victimAddr.f.tag = victimTag;
    end

    // result pulses
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            LoadBack <= 1'b0;
            StoreBack <= 1'b0;
            MissAble <= 1'b0;
            WriteBackAble <= 1'b0;
        end else begin
            LoadBack <= hitEn && !reqIsStore;
            StoreBack <= wrWordEn;
            MissAble <= missEn;
            WriteBackAble <= cleanEn;
        end
    end

    always_ff @(posedge Clk) begin
        LoadBackPtr <= reqPtr;
        LoadBackData <= hitLine[reqAddr.f.wordSel * $bits(LoadBackData) +: $bits(LoadBackData)];
        StoreBackPtr <= reqPtr;
        MissAddr <= lineAddr;
        MissWay <= victimWay;
        MissIsStore <= reqIsStore;
        MissPtr <= reqPtr;
        MissStoreData <= reqData;
        WriteBackAddr <= victimAddr;
        WriteBackLine <= victimLine;
    end

    // refills never install a line twice in a set
    singleHit: assert property (@(posedge Clk) disable iff (!rstN)
        reqValid |-> $onehot0(hitWay));

endmodule

//--- dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop #(
    parameter int AgeBits = 3
) (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   LoadAble,
    input  dcachePkg::cacheAddrT   LoadAddr,
    input  logic [2:0]             LoadPtr,
    input  logic                   StoreAble,
    input  dcachePkg::cacheAddrT   StoreAddr,
    input  logic [2:0]             StorePtr,
    input  logic [31:0]            StoreData,
    input  logic                   RefillAble,
    input  dcachePkg::cacheAddrT   RefillAddr,
    input  dcachePkg::wayVecT      RefillWay,
    input  dcachePkg::lineT        RefillLine,
    output logic                   LoadSuccess,
    output logic                   StoreSuccess,
    output logic                   LoadBack,
    output logic [2:0]             LoadBackPtr,
    output logic [31:0]            LoadBackData,
    output logic                   StoreBack,
    output logic [2:0]             StoreBackPtr,
    output logic                   MissAble,
    output dcachePkg::cacheAddrT   MissAddr,
    output dcachePkg::wayVecT      MissWay,
    output logic                   MissIsStore,
    output logic [2:0]             MissPtr,
    output logic [31:0]            MissStoreData,
    output logic                   WriteBackAble,
    output dcachePkg::cacheAddrT   WriteBackAddr,
    output dcachePkg::lineT        WriteBackLine
);

    logic reqValid;
    logic reqIsStore;
    dcachePkg::cacheAddrT reqAddr;
    logic [2:0] reqPtr;
    logic [31:0] reqData;
    logic [dcachePkg::NumWays-1:0][dcachePkg::TagW-1:0] wayTags;
    dcachePkg::wayVecT wayValid;
    dcachePkg::lineT [dcachePkg::NumWays-1:0] wayLines;
    dcachePkg::wayVecT victimWay;
    logic victimDirty;
    logic hitEn;
    dcachePkg::wayVecT hitWay;
    logic wrWordEn;
    logic dirtySetEn;
    logic cleanEn;
    dcachePkg::wayVecT cleanWay;

    reqArbiter uArbiter (
        .Clk, .rstN, .LoadAble, .LoadAddr, .LoadPtr, .StoreAble, .StoreAddr, .StorePtr,
        .StoreData, .RefillAble, .LoadSuccess, .StoreSuccess, .reqValid, .reqIsStore,
        .reqAddr, .reqPtr, .reqData
    );

    tagArray uTags (
        .Clk, .rstN, .lookIndex(reqAddr.f.index), .RefillAble, .RefillAddr, .RefillWay,
        .wayTags, .wayValid
    );

    dataArray uData (
        .Clk, .lookIndex(reqAddr.f.index), .wrWordEn, .wrWay(hitWay),
        .wrWordSel(reqAddr.f.wordSel), .wrWord(reqData), .RefillAble, .RefillAddr,
        .RefillWay, .RefillLine, .wayLines
    );

    replacementState #(.AgeBits(AgeBits)) uRepl (
        .Clk, .rstN, .lookIndex(reqAddr.f.index), .wayValid, .hitEn, .hitWay, .dirtySetEn,
        .cleanEn, .cleanWay, .RefillAble, .RefillAddr, .RefillWay, .victimWay, .victimDirty
    );

    lookupStage uLookup (
        .Clk, .rstN, .reqValid, .reqIsStore, .reqAddr, .reqPtr, .reqData, .wayTags,
        .wayValid, .wayLines, .victimWay, .victimDirty, .hitEn, .hitWay, .wrWordEn,
        .dirtySetEn, .cleanEn, .cleanWay, .LoadBack, .LoadBackPtr, .LoadBackData,
        .StoreBack, .StoreBackPtr, .MissAble, .MissAddr, .MissWay, .MissIsStore, .MissPtr,
        .MissStoreData, .WriteBackAble, .WriteBackAddr, .WriteBackLine
    );

endmodule

//--- dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

    localparam int OpLoad = 0;
    localparam int OpStore = 1;
    localparam int OpBoth = 2;
    localparam int OpRefill = 3;
    localparam int KLoadHit = 0;
    localparam int KStoreHit = 1;
    localparam int KMiss = 2;
    localparam int AgeMax = 7;
    localparam int Timeout = 20;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [2:0]  ptr;
        logic [31:0] data;
        logic [3:0]  way;
        logic [1:0]  kind;
    } entryT;

    // one expected result, queued in grant order
    typedef struct packed {
        logic [1:0]   kind;
        logic [2:0]   ptr;
        logic [31:0]  data;
        logic [31:0]  addr;
        logic [3:0]   way;
        logic         isStore;
        logic         wb;
        logic [31:0]  wbAddr;
        logic [255:0] wbLine;
    } expectT;

    logic Clk, rstN, LoadAble, StoreAble, RefillAble;
    logic LoadSuccess, StoreSuccess, LoadBack, StoreBack, MissAble, MissIsStore, WriteBackAble;
    logic [2:0] LoadPtr, StorePtr, LoadBackPtr, StoreBackPtr, MissPtr;
    logic [31:0] StoreData, LoadBackData, MissStoreData;
    dcachePkg::cacheAddrT LoadAddr, StoreAddr, RefillAddr, MissAddr, WriteBackAddr;
    dcachePkg::wayVecT RefillWay, MissWay;
    dcachePkg::lineT RefillLine, WriteBackLine;

    // ==============================
    // reference model state
    // ==============================
    logic [19:0] mTag [128][4];
    logic [255:0] mLine [128][4];
    bit mValid [128][4];
    bit mDirty [128][4];
    int mAge [128][4];
    bit lastTieLoad;
    entryT stim [$];
    expectT expQ [$];
    integer seed;
    int errors;
    int checks;

    dcacheTop u_dut (.*);

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    task automatic expectEq(input string name, input logic [255:0] exp, input logic [255:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic addEntry(input int op, input logic [19:0] tag, input int idx, input int word,
                            input int ptr, input logic [31:0] data, input logic [3:0] way,
                            input int kind);
        entryT e;
        e.op = op[1:0];
        e.addr = {tag, idx[6:0], word[2:0], 2'b00};
        e.ptr = ptr[2:0];
        e.data = data;
        e.way = way;
        e.kind = kind[1:0];
        stim.push_back(e);
    endtask

    // a hit or a refill makes one way youngest and ages the rest
    task automatic bumpAges(input int si, input int young);
        for (int w = 0; w < 4; w++) begin
            if (w == young) begin
                mAge[si][w] = 0;
            end else if (mAge[si][w] < AgeMax) begin
                mAge[si][w] = mAge[si][w] + 1;
            end
        end
    endtask

    task automatic modelRequest(input dcachePkg::cacheAddrT a, input bit isStore,
                                input logic [2:0] ptr, input logic [31:0] data, input int kind);
        expectT x;
        int si;
        int hw;
        int v;
        si = a.f.index;
        hw = -1;
        v = -1;
        x = '0;
        x.kind = kind[1:0];
        x.ptr = ptr;
        x.data = data;
        x.isStore = isStore;
        x.addr = {a.raw[31:5], 5'b0};
        for (int w = 3; w >= 0; w--) begin
            if (mValid[si][w] && mTag[si][w] == a.f.tag) begin
                hw = w;
            end
            if (!mValid[si][w]) begin
                v = w;
            end
        end
        if (hw >= 0) begin
            x.data = mLine[si][hw][a.f.wordSel * 32 +: 32];
            bumpAges(si, hw);
            if (isStore) begin
                mLine[si][hw][a.f.wordSel * 32 +: 32] = data;
                mDirty[si][hw] = 1'b1;
            end
        end else begin
            // all ways valid so take the oldest, lowest index first
            if (v < 0) begin
                v = 0;
                for (int w = 1; w < 4; w++) begin
                    if (mAge[si][w] > mAge[si][v]) begin
                        v = w;
                    end
                end
            end
            x.way = 4'b0001 << v;
            x.wb = mDirty[si][v];
            x.wbAddr = {mTag[si][v], a.f.index, 5'b0};
            x.wbLine = mLine[si][v];
            mDirty[si][v] = 1'b0;
        end
        expQ.push_back(x);
    endtask

    task automatic checkResult();
        expectT x;
        int kind;
        kind = LoadBack ? KLoadHit : (StoreBack ? KStoreHit : KMiss);
        if ($countones({LoadBack, StoreBack, MissAble}) > 1) begin
            errors++;
            $display("more than one result pulse at %0t", $time);
        end
        if (expQ.size() == 0) begin
            errors++;
            $display("result pulse at %0t with no request outstanding", $time);
        end else begin
            x = expQ.pop_front();
            expectEq("result kind", x.kind, kind);
            if (kind == KLoadHit) begin
                expectEq("LoadBackPtr", x.ptr, LoadBackPtr);
                expectEq("LoadBackData", x.data, LoadBackData);
            end else if (kind == KStoreHit) begin
                expectEq("StoreBackPtr", x.ptr, StoreBackPtr);
            end else begin
                expectEq("MissAddr", x.addr, MissAddr);
                expectEq("MissWay", x.way, MissWay);
                expectEq("MissIsStore", x.isStore, MissIsStore);
                expectEq("MissPtr", x.ptr, MissPtr);
                if (x.isStore) begin
                    expectEq("MissStoreData", x.data, MissStoreData);
                end
            end
            expectEq("WriteBackAble", x.wb, WriteBackAble);
            if (x.wb && WriteBackAble) begin
                expectEq("WriteBackAddr", x.wbAddr, WriteBackAddr);
                expectEq("WriteBackLine", x.wbLine, WriteBackLine);
            end
        end
    endtask

    task automatic doRefill(input entryT e);
        dcachePkg::cacheAddrT a;
        dcachePkg::lineT line;
        a = e.addr;
        for (int i = 0; i < 8; i++) begin
            line[i * 32 +: 32] = $random(seed);
        end
        RefillAble = 1'b1;
        RefillAddr = a;
        RefillWay = e.way;
        RefillLine = line;
        @(posedge Clk);
        #1;
        RefillAble = 1'b0;
        for (int w = 0; w < 4; w++) begin
            if (e.way[w]) begin
                mTag[a.f.index][w] = a.f.tag;
                mValid[a.f.index][w] = 1'b1;
                mDirty[a.f.index][w] = 1'b0;
                mLine[a.f.index][w] = line;
                bumpAges(a.f.index, w);
            end
        end
    endtask

    task automatic issueRequest(input entryT e);
        int cycles;
        int grants;
        int results;
        int needed;
        bit loadFirst;
        needed = (e.op == OpBoth) ? 2 : 1;
        loadFirst = (e.op == OpLoad) || (e.op == OpBoth && !lastTieLoad);
        if (e.op == OpBoth) begin
            lastTieLoad = loadFirst;
        end
        LoadAble = (e.op != OpStore);
        LoadAddr = e.addr;
        LoadPtr = e.ptr;
        StoreAble = (e.op != OpLoad);
        StoreAddr = e.addr;
        StorePtr = e.ptr ^ 3'b100;
        StoreData = e.data;
        cycles = 0;
        grants = 0;
        results = 0;
        while (results < needed && cycles < Timeout) begin
            @(posedge Clk);
            #1;
            cycles++;
            if (LoadSuccess && StoreSuccess) begin
                errors++;
                $display("load and store granted together at %0t", $time);
            end
            if (grants == 0 && (LoadSuccess || StoreSuccess)) begin
                expectEq("LoadSuccess", loadFirst, LoadSuccess);
            end
            if (LoadSuccess) begin
                LoadAble = 1'b0;
                modelRequest(e.addr, 1'b0, e.ptr, e.data, e.kind);
                grants++;
            end
            if (StoreSuccess) begin
                StoreAble = 1'b0;
                modelRequest(e.addr, 1'b1, e.ptr ^ 3'b100, e.data, e.kind);
                grants++;
            end
            if (LoadBack || StoreBack || MissAble) begin
                results++;
                if (needed == 1) begin
                    expectEq("result latency", 2, cycles);
                end
                checkResult();
            end else begin
                expectEq("WriteBackAble", 0, WriteBackAble);
            end
        end
        if (results < needed) begin
            errors++;
            $display("timeout at %0t: only %0d of %0d results came back for address 0x%h",
                     $time, results, needed, e.addr);
            LoadAble = 1'b0;
            StoreAble = 1'b0;
        end
    endtask

    // ==============================
    // stimulus table
    // ==============================
    task automatic buildTable();
        // cold miss then a refill of way 0 and hits on that line
        addEntry(OpLoad, 20'h12345, 5, 3, 1, 32'h0, 4'b0000, KMiss);
        addEntry(OpRefill, 20'h12345, 5, 0, 0, 32'h0, 4'b0001, 0);
        addEntry(OpLoad, 20'h12345, 5, 3, 2, 32'h0, 4'b0000, KLoadHit);
        addEntry(OpStore, 20'h12345, 5, 3, 3, 32'hdeadbeef, 4'b0000, KStoreHit);
        addEntry(OpLoad, 20'h12345, 5, 3, 4, 32'h0, 4'b0000, KLoadHit);
        addEntry(OpLoad, 20'h12345, 5, 6, 5, 32'h0, 4'b0000, KLoadHit);
        // load and store ties on an empty set
        addEntry(OpBoth, 20'h00abc, 100, 1, 0, 32'h11112222, 4'b0000, KMiss);
        addEntry(OpBoth, 20'h00abc, 100, 2, 1, 32'h33334444, 4'b0000, KMiss);
        addEntry(OpBoth, 20'h00abc, 100, 3, 2, 32'h55556666, 4'b0000, KMiss);
        // fill set 9 and dirty way 0 before aging it out
        addEntry(OpRefill, 20'ha0000, 9, 0, 0, 32'h0, 4'b0001, 0);
        addEntry(OpRefill, 20'ha0001, 9, 0, 0, 32'h0, 4'b0010, 0);
        addEntry(OpRefill, 20'ha0002, 9, 0, 0, 32'h0, 4'b0100, 0);
        addEntry(OpRefill, 20'ha0003, 9, 0, 0, 32'h0, 4'b1000, 0);
        addEntry(OpStore, 20'ha0000, 9, 2, 6, 32'h600dcafe, 4'b0000, KStoreHit);
        addEntry(OpLoad, 20'ha0001, 9, 0, 7, 32'h0, 4'b0000, KLoadHit);
        addEntry(OpLoad, 20'ha0002, 9, 7, 0, 32'h0, 4'b0000, KLoadHit);
        addEntry(OpLoad, 20'ha0003, 9, 4, 1, 32'h0, 4'b0000, KLoadHit);
        addEntry(OpLoad, 20'ha0004, 9, 0, 2, 32'h0, 4'b0000, KMiss);
        addEntry(OpLoad, 20'ha0005, 9, 0, 3, 32'h0, 4'b0000, KMiss);
        // store miss then a store hit once the line is in
        addEntry(OpStore, 20'h55555, 20, 1, 5, 32'hcafef00d, 4'b0000, KMiss);
        addEntry(OpRefill, 20'h55555, 20, 0, 0, 32'h0, 4'b0001, 0);
        addEntry(OpStore, 20'h55555, 20, 4, 6, 32'h0badf00d, 4'b0000, KStoreHit);
        addEntry(OpLoad, 20'h55555, 20, 4, 7, 32'h0, 4'b0000, KLoadHit);
    endtask

    initial begin
        seed = 70;
        errors = 0;
        checks = 0;
        lastTieLoad = 1'b0;
        rstN = 1'b0;
        LoadAble = 1'b0;
        LoadAddr = '0;
        LoadPtr = '0;
        StoreAble = 1'b0;
        StoreAddr = '0;
        StorePtr = '0;
        StoreData = '0;
        RefillAble = 1'b0;
        RefillAddr = '0;
        RefillWay = '0;
        RefillLine = '0;
        buildTable();
        repeat (16) @(posedge Clk);
        #1;
        rstN = 1'b1;
        expectEq("LoadSuccess", 0, LoadSuccess);
        expectEq("StoreSuccess", 0, StoreSuccess);
        expectEq("LoadBack", 0, LoadBack);
        expectEq("StoreBack", 0, StoreBack);
        expectEq("MissAble", 0, MissAble);
        expectEq("WriteBackAble", 0, WriteBackAble);
        foreach (stim[i]) begin
            if (stim[i].op == OpRefill) begin
                doRefill(stim[i]);
            end else begin
                issueRequest(stim[i]);
            end
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected results never arrived", expQ.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
dcachePkg.sv
reqArbiter.sv
tagArray.sv
dataArray.sv
replacementState.sv
lookupStage.sv
dcacheTop.sv
dcacheTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dcacheTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
